// ==== tb.f ====
+incdir+.
fp16_pkg.sv
fp16_add.sv
fp16_mul.sv
fp16_fpu.sv
fp16_alu_wrap.sv
fp16_alu_top.sv
tb_fp16_alu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the FP16 ALU testbench with Verilator, run it, then scan the log

verilator --binary --timing --assert -Wno-fatal -f tb.f \
	--top-module tb_fp16_alu -o tb_fp16_alu > build.log 2>&1 ||
	{ cat build.log; echo "build error"; exit 1; }

./obj_dir/tb_fp16_alu > sim.log 2>&1
cat sim.log

grep -qx "test passed" sim.log && echo "simulation ok" ||
	{ echo "simulation reported failure"; exit 1; }

// ==== tb_fp16_tasks.svh ====
//--------------------
// Request and result tasks
// Directed tests for arithmetic, rounding, specials, range, streaming, latency
//--------------------

`ifndef TB_FP16_TASKS_SVH
`define TB_FP16_TASKS_SVH

// Exact encoding of a small non-negative integer
function automatic fp16_t int_to_fp16(input int n);
	int    p;
	fp16_t v;
	v = '0;
	p = 0;
	if (n > 0) begin
		for (int i = 0; i < 11; i++) begin
			if (n[i]) begin
				p = i;
			end
		end
		v[14:10] = 5'(p + EXP_BIAS);
		// Leading one lands on the hidden bit and drops out
		v[9:0]   = 10'(n << (FRAC_W - p));
	end
	return v;
endfunction

// Present a request and hold it until the accepting edge
task automatic send_req(input fp16_t a, input fp16_t b, input alu_op_t op);
	int waited;
	waited = 0;
	alu_a  <= a;
	alu_b  <= b;
	alu_op <= op;
	valid  <= 1'b1;
	@(negedge clk);
	while (!ready && waited < WAIT_LIMIT) begin
		@(negedge clk);
		waited++;
	end
	if (!ready) begin
		$display("request was not accepted within %0d cycles", WAIT_LIMIT);
		errors++;
	end
	@(posedge clk);
endtask

// Wait for a result, out_ready is high so it leaves on the next edge
task automatic wait_result(output fp16_t res);
	int waited;
	waited = 0;
	@(negedge clk);
	while (!out_valid && waited < WAIT_LIMIT) begin
		@(negedge clk);
		waited++;
	end
	if (!out_valid) begin
		$display("no result appeared within %0d cycles", WAIT_LIMIT);
		errors++;
	end
	res = alu_res;
	@(posedge clk);
endtask

task automatic pulse_clear();
	flags_clr <= 1'b1;
	@(posedge clk);
	flags_clr <= 1'b0;
endtask

// One isolated operation with cleared flags before it
task automatic run_op(input fp16_t a, input fp16_t b, input alu_op_t op,
		input fp16_t exp_res, input status_t exp_flags, input string what);
	fp16_t res;
	pulse_clear();
	send_req(a, b, op);
	valid <= 1'b0;
	wait_result(res);
	check_value(32'(res), 32'(exp_res), {what, " result"});
	@(negedge clk);
	check_value(32'(flags), 32'(exp_flags), {what, " flags"});
	@(posedge clk);
endtask

task automatic reset_state_test();
	int start_errors;
	start_errors = errors;
	@(negedge clk);
	check_value(32'(out_valid), 0, "out_valid after reset");
	check_value(32'(busy), 0, "busy after reset");
	check_value(32'(ready), 1, "ready after reset");
	check_value(32'(flags), 0, "flags after reset");
	@(posedge clk);
	report_test("reset state", start_errors);
endtask

task automatic exact_arith_test();
	int start_errors;
	start_errors = errors;
	run_op(16'h3C00, 16'h4000, ALU_ADD, 16'h4200, '0, "1.0+2.0");
	run_op(16'h4200, 16'h3C00, ALU_SUB, 16'h4000, '0, "3.0-1.0");
	run_op(16'h3E00, 16'h4000, ALU_MUL, 16'h4200, '0, "1.5*2.0");
	// Code 3 behaves as multiply
	run_op(16'h3E00, 16'h4000, 2'd3, 16'h4200, '0, "1.5*2.0 by code 3");
	report_test("exact arithmetic", start_errors);
endtask

task automatic rounding_test();
	int start_errors;
	start_errors = errors;
	// Half an ulp above 1.0, tie stays on even 3C00
	run_op(16'h3C00, 16'h1000, ALU_ADD, 16'h3C00, NX_FLAG, "1.0+2^-11");
	// One and a half ulp, tie goes up to even 3C02
	run_op(16'h3C00, 16'h1600, ALU_ADD, 16'h3C02, NX_FLAG, "1.0+3*2^-11");
	pulse_clear();
	@(negedge clk);
	check_value(32'(flags), 0, "flags after clear");
	@(posedge clk);
	report_test("rounding", start_errors);
endtask

task automatic special_value_test();
	int start_errors;
	start_errors = errors;
	run_op(16'h7C00, 16'hFC00, ALU_ADD, QNAN, NV_FLAG, "+inf + -inf");
	run_op(16'h0000, 16'h7C00, ALU_MUL, QNAN, NV_FLAG, "0*inf");
	run_op(16'h7E00, 16'h3C00, ALU_ADD, QNAN, '0, "quiet NaN operand");
	run_op(16'h7C01, 16'h3C00, ALU_ADD, QNAN, NV_FLAG, "signaling NaN operand");
	run_op(16'h8000, 16'h8000, ALU_ADD, 16'h8000, '0, "-0 + -0");
	report_test("special values", start_errors);
endtask

task automatic range_test();
	int start_errors;
	start_errors = errors;
	run_op(16'h7BFF, 16'h4000, ALU_MUL, 16'h7C00, OF_FLAG | NX_FLAG, "max*2.0");
	run_op(16'h0400, 16'h0400, ALU_MUL, 16'h0000, UF_FLAG | NX_FLAG, "min*min");
	// Subnormal reads as zero
	run_op(16'h0001, 16'h0000, ALU_ADD, 16'h0000, '0, "subnormal+0");
	report_test("range limits", start_errors);
endtask

// Back-to-back k+1.0 under random back-pressure
task automatic stream_test();
	int    start_errors;
	int    got;
	int    cycles;
	fp16_t expect_q[$];
	fp16_t held;
	logic  stalled;
	start_errors = errors;
	for (int k = 0; k < STREAM_LEN; k++) begin
		expect_q.push_back(int_to_fp16(k + 1));
	end
	fork
		begin
			for (int k = 0; k < STREAM_LEN; k++) begin
				send_req(int_to_fp16(k), 16'h3C00, ALU_ADD);
			end
			valid <= 1'b0;
		end
		begin
			got     = 0;
			cycles  = 0;
			stalled = 1'b0;
			held    = '0;
			while (got < STREAM_LEN && cycles < STREAM_LEN * 8) begin
				@(posedge clk);
				out_ready <= 1'($random(seed));
				@(negedge clk);
				cycles++;
				if (stalled) begin
					check_value(32'(alu_res), 32'(held), "result held while stalled");
				end
				stalled = out_valid && !out_ready;
				held    = alu_res;
				if (out_valid && out_ready) begin
					check_value(32'(alu_res), 32'(expect_q.pop_front()),
						$sformatf("stream result %0d", got));
					got++;
				end
			end
			if (got < STREAM_LEN) begin
				$display("stream delivered only %0d of %0d results", got, STREAM_LEN);
				errors++;
			end
		end
	join
	// Last result leaves on this edge
	@(posedge clk);
	out_ready <= 1'b1;
	@(negedge clk);
	check_value(32'(busy), 0, "busy after stream drained");
	@(posedge clk);
	report_test("streaming", start_errors);
endtask

// Result must be presented at edge N+PIPE_DEPTH, not earlier
task automatic latency_test();
	int start_errors;
	start_errors = errors;
	send_req(16'h3C00, 16'h4000, ALU_ADD);
	valid <= 1'b0;
	for (int i = 0; i < PIPE_DEPTH - 1; i++) begin
		@(negedge clk);
		check_value(32'(out_valid), 0, $sformatf("out_valid %0d edges after accept", i));
		@(posedge clk);
	end
	@(negedge clk);
	check_value(32'(out_valid), 1, "out_valid at edge N+2");
	check_value(32'(alu_res), 32'(16'h4200), "latency result");
	@(posedge clk);
	report_test("latency", start_errors);
endtask

`endif

// ==== tb_fp16_alu.sv ====
//--------------------
// FP16 ALU testbench top
// Clock, reset, DUT, watchdog
// Value check, test reports, test sequence
//--------------------

module tb_fp16_alu;
	timeunit 1ns;
	timeprecision 1ps;

	import fp16_pkg::*;

	localparam int RST_CYCLES = 16;
	localparam int WAIT_LIMIT = 20;
	localparam int STREAM_LEN = 30;
	// Operations issued by all tests together
	localparam int NUM_OPS = 45;
	localparam int WATCHDOG_CYCLES = NUM_OPS * (PIPE_DEPTH + 8) + RST_CYCLES;

	// Single flag masks
	localparam status_t NV_FLAG = 4'(1 << ST_NV);
	localparam status_t OF_FLAG = 4'(1 << ST_OF);
	localparam status_t UF_FLAG = 4'(1 << ST_UF);
	localparam status_t NX_FLAG = 4'(1 << ST_NX);

	logic    clk = 1'b0;
	logic    rst;
	fp16_t   alu_a;
	fp16_t   alu_b;
	alu_op_t alu_op;
	logic    valid;
	logic    ready;
	fp16_t   alu_res;
	logic    out_valid;
	logic    out_ready;
	logic    flags_clr;
	status_t flags;
	logic    busy;

	int     errors;
	int     tests_ok;
	int     tests_bad;
	// Back-pressure pattern source
	integer seed = 32'h6918_482e;

	always #50 clk = ~clk;

	fp16_alu_top dut_i (
		.clk_i      (clk),
		.rst_i      (rst),
		.alu_a_i    (alu_a),
		.alu_b_i    (alu_b),
		.alu_op_i   (alu_op),
		.valid_i    (valid),
		.ready_o    (ready),
		.alu_res_o  (alu_res),
		.out_valid_o(out_valid),
		.out_ready_i(out_ready),
		.flags_clr_i(flags_clr),
		.flags_o    (flags),
		.busy_o     (busy)
	);

	// Compare one observed value with its expected value
	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("mismatch at %0d ns: %s, got %0h, expected %0h",
				$time, what, actual, expected);
			errors++;
		end
	endtask

	// One line per finished test
	task automatic report_test(input string name, input int start_errors);
		if (errors == start_errors) begin
			tests_ok++;
			$display("%s: ok", name);
		end else begin
			tests_bad++;
			$display("%s: %0d errors", name, errors - start_errors);
		end
	endtask

	`include "tb_fp16_tasks.svh"

	// Hard stop if the DUT hangs
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("simulation timed out after %0d cycles", WATCHDOG_CYCLES);
		$display("test failed");
		$finish;
	end

	initial begin
		rst       = 1'b1;
		alu_a     = '0;
		alu_b     = '0;
		alu_op    = ALU_ADD;
		valid     = 1'b0;
		out_ready = 1'b1;
		flags_clr = 1'b0;
		errors    = 0;
		tests_ok  = 0;
		tests_bad = 0;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;

		// Every test starts and ends on a rising edge
		reset_state_test();
		exact_arith_test();
		rounding_test();
		special_value_test();
		range_test();
		stream_test();
		latency_test();

		$display("%0d tests ok, %0d tests with errors, %0d errors",
			tests_ok, tests_bad, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== fp16_alu_top.sv ====
//--------------------
// FP16 ALU top level
// Wrapper in front of the pipelined core
//--------------------

module fp16_alu_top (
	input  logic              clk_i,
	input  logic              rst_i,
	input  fp16_pkg::fp16_t   alu_a_i,
	input  fp16_pkg::fp16_t   alu_b_i,
	input  fp16_pkg::alu_op_t alu_op_i,
	input  logic              valid_i,
	output logic              ready_o,
	output fp16_pkg::fp16_t   alu_res_o,
	output logic              out_valid_o,
	input  logic              out_ready_i,
	input  logic              flags_clr_i,
	output fp16_pkg::status_t flags_o,
	output logic              busy_o
);

	// Wrapper to core request
	fp16_pkg::fp16_t   fpu_a;
	fp16_pkg::fp16_t   fpu_b;
	fp16_pkg::fpu_op_e fpu_op;
	logic              fpu_in_valid;
	logic              fpu_in_ready;
	// Core to wrapper status
	fp16_pkg::status_t fpu_status;
	logic              fpu_res_fire;

	fp16_alu_wrap wrap_u (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.alu_a_i       (alu_a_i),
		.alu_b_i       (alu_b_i),
		.alu_op_i      (alu_op_i),
		.valid_i       (valid_i),
		.ready_o       (ready_o),
		.operand_a_o   (fpu_a),
		.operand_b_o   (fpu_b),
		.op_o          (fpu_op),
		.in_valid_o    (fpu_in_valid),
		.fpu_in_ready_i(fpu_in_ready),
		.fpu_status_i  (fpu_status),
		.fpu_res_fire_i(fpu_res_fire),
		.flags_clr_i   (flags_clr_i),
		.flags_o       (flags_o)
	);

	fp16_fpu fpu_u (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.operand_a_i(fpu_a),
		.operand_b_i(fpu_b),
		.op_i       (fpu_op),
		.in_valid_i (fpu_in_valid),
		.in_ready_o (fpu_in_ready),
		.result_o   (alu_res_o),
		.status_o   (fpu_status),
		.out_valid_o(out_valid_o),
		.out_ready_i(out_ready_i),
		.res_fire_o (fpu_res_fire),
		.busy_o     (busy_o)
	);

endmodule

// ==== fp16_alu_wrap.sv ====
//--------------------
// ALU request wrapper
// Opcode decode, subtract as negated add
// Sticky exception flags
//--------------------

module fp16_alu_wrap (
	input  logic              clk_i,
	input  logic              rst_i,
	input  fp16_pkg::fp16_t   alu_a_i,
	input  fp16_pkg::fp16_t   alu_b_i,
	input  fp16_pkg::alu_op_t alu_op_i,
	input  logic              valid_i,
	output logic              ready_o,
	output fp16_pkg::fp16_t   operand_a_o,
	output fp16_pkg::fp16_t   operand_b_o,
	output fp16_pkg::fpu_op_e op_o,
	output logic              in_valid_o,
	input  logic              fpu_in_ready_i,
	input  fp16_pkg::status_t fpu_status_i,
	input  logic              fpu_res_fire_i,
	input  logic              flags_clr_i,
	output fp16_pkg::status_t flags_o
);
	import fp16_pkg::*;

	status_t flags_q;

	// Handshake goes straight through
	assign ready_o     = fpu_in_ready_i;
	assign in_valid_o  = valid_i;
	assign operand_a_o = alu_a_i;

	// Operation decode
	always_comb begin
		operand_b_o = alu_b_i;
		case (alu_op_i)
			ALU_ADD: op_o = FPU_ADD;
			ALU_SUB: begin
				// Flip sign of b
				op_o        = FPU_ADD;
				operand_b_o = {~alu_b_i[15], alu_b_i[14:0]};
			end
			ALU_MUL: op_o = FPU_MUL;
			// Unused code 3 runs as multiply
			default: op_o = FPU_MUL;
		endcase
	end

	// Flags accrue on every result transfer
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			flags_q <= '0;
		end else if (flags_clr_i) begin
			// Keep only a result leaving in the clear cycle
			flags_q <= fpu_res_fire_i ? fpu_status_i : '0;
		end else if (fpu_res_fire_i) begin
			flags_q <= flags_q | fpu_status_i;
		end
	end

	assign flags_o = flags_q;

	// Set flags survive until the host clears them
	assert property (@(posedge clk_i) disable iff (rst_i)
		!flags_clr_i |=> (flags_o & $past(flags_o)) == $past(flags_o));

endmodule

// ==== fp16_fpu.sv ====
//--------------------
// FP16 pipelined core
// Operand stage, result stage, valid/ready stall logic
//--------------------

module fp16_fpu (
	input  logic              clk_i,
	input  logic              rst_i,
	input  fp16_pkg::fp16_t   operand_a_i,
	input  fp16_pkg::fp16_t   operand_b_i,
	input  fp16_pkg::fpu_op_e op_i,
	input  logic              in_valid_i,
	output logic              in_ready_o,
	output fp16_pkg::fp16_t   result_o,
	output fp16_pkg::status_t status_o,
	output logic              out_valid_o,
	input  logic              out_ready_i,
	output logic              res_fire_o,
	output logic              busy_o
);
	import fp16_pkg::*;

	// Stage valid bits, index 0 is operand stage
	logic [PIPE_DEPTH-1:0] vld_q;

	fp16_t   s1_a_q, s1_b_q;
	fpu_op_e s1_op_q;
	fp16_t   s2_res_q;
	status_t s2_st_q;

	fp16_t   add_res, mul_res, s1_res;
	status_t add_st, mul_st, s1_st;
	logic    in_fire, s1_adv, s2_free, out_fire;

	fp16_add add_u (
		.a_i     (s1_a_q),
		.b_i     (s1_b_q),
		.sum_o   (add_res),
		.status_o(add_st)
	);

	fp16_mul mul_u (
		.a_i     (s1_a_q),
		.b_i     (s1_b_q),
		.prod_o  (mul_res),
		.status_o(mul_st)
	);

	// Pick the datapath of the held operation
	assign s1_res = (s1_op_q == FPU_MUL) ? mul_res : add_res;
	assign s1_st  = (s1_op_q == FPU_MUL) ? mul_st : add_st;

	// Result stage frees up when empty or drained this cycle
	assign out_fire   = vld_q[PIPE_DEPTH-1] & out_ready_i;
	assign s2_free    = !vld_q[PIPE_DEPTH-1] | out_ready_i;
	assign s1_adv     = vld_q[0] & s2_free;
	// Accept while operand stage is empty or moving on
	assign in_ready_o = !vld_q[0] | s2_free;
	assign in_fire    = in_valid_i & in_ready_o;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			vld_q <= '0;
		end else begin
			if (in_ready_o) begin
				vld_q[0] <= in_valid_i;
			end
			if (s2_free) begin
				vld_q[PIPE_DEPTH-1] <= vld_q[0];
			end
		end
	end

	// Payload registers
	always_ff @(posedge clk_i) begin
		if (in_fire) begin
			s1_a_q  <= operand_a_i;
			s1_b_q  <= operand_b_i;
			s1_op_q <= op_i;
		end
		if (s1_adv) begin
			s2_res_q <= s1_res;
			s2_st_q  <= s1_st;
		end
	end

	assign result_o    = s2_res_q;
	assign status_o    = s2_st_q;
	assign out_valid_o = vld_q[PIPE_DEPTH-1];
	assign res_fire_o  = out_fire;
	assign busy_o      = |vld_q;

	// A stalled result must not change under the host
	assert property (@(posedge clk_i) disable iff (rst_i)
		out_valid_o && !out_ready_i |=> $stable(result_o) && $stable(status_o));

	// A stalled result stays offered until the host takes it
	assert property (@(posedge clk_i) disable iff (rst_i)
		out_valid_o && !out_ready_i |=> out_valid_o);

endmodule

// ==== fp16_mul.sv ====
//--------------------
// FP16 multiplier datapath
// Significand product, one-place normalization
// Round-to-nearest-even and range flags
//--------------------

module fp16_mul (
	input  fp16_pkg::fp16_t   a_i,
	input  fp16_pkg::fp16_t   b_i,
	output fp16_pkg::fp16_t   prod_o,
	output fp16_pkg::status_t status_o
);
	import fp16_pkg::*;

	logic              sa, sb, sp;
	logic [EXP_W-1:0]  ea, eb;
	logic [FRAC_W-1:0] fa, fb;
	logic              a_zero, b_zero, a_inf, b_inf, a_nan, b_nan, any_snan;
	logic [21:0]       prod;
	logic signed [7:0] exp_s, exp_n, exp_r;
	logic [10:0]       sig;
	logic              guard, sticky, rnd_up;
	logic [11:0]       sig_r;
	logic [FRAC_W-1:0] frac_r;

	// Unpack fields
	assign sa = a_i[15];
	assign sb = b_i[15];
	assign ea = a_i[FRAC_W +: EXP_W];
	assign eb = b_i[FRAC_W +: EXP_W];
	assign fa = a_i[FRAC_W-1:0];
	assign fb = b_i[FRAC_W-1:0];

	// Result sign
	assign sp = sa ^ sb;

	// Operand classes, subnormals read as zero
	assign a_zero = (ea == '0);
	assign b_zero = (eb == '0);
	assign a_inf  = (ea == EXP_MAX) && (fa == '0);
	assign b_inf  = (eb == EXP_MAX) && (fb == '0);
	assign a_nan  = (ea == EXP_MAX) && (fa != '0);
	assign b_nan  = (eb == EXP_MAX) && (fb != '0);
	assign any_snan = (a_nan && !fa[FRAC_W-1]) || (b_nan && !fb[FRAC_W-1]);

	// 11x11 significand product lies in [2^20, 2^22)
	assign prod = {1'b1, fa} * {1'b1, fb};

	// Biased exponent sum
	assign exp_s = $signed({3'b000, ea}) + $signed({3'b000, eb}) - 8'(EXP_BIAS);

	// Normalize by at most one place
	always_comb begin
		if (prod[21]) begin
			sig    = prod[21:11];
			guard  = prod[10];
			sticky = |prod[9:0];
			exp_n  = exp_s + 8'sd1;
		end else begin
			sig    = prod[20:10];
			guard  = prod[9];
			sticky = |prod[8:0];
			exp_n  = exp_s;
		end
	end

	// Ties go to the even significand
	assign rnd_up = guard & (sticky | sig[0]);
	assign sig_r  = {1'b0, sig} + {11'b0, rnd_up};
	assign exp_r  = sig_r[11] ? exp_n + 8'sd1 : exp_n;
	assign frac_r = sig_r[11] ? sig_r[10:1] : sig_r[9:0];

	// Result selection
	always_comb begin
		prod_o   = '0;
		status_o = '0;
		if (a_nan || b_nan) begin
			prod_o = QNAN;
			status_o[ST_NV] = any_snan;
		end else if ((a_inf && b_zero) || (b_inf && a_zero)) begin
			// Zero times infinity is invalid
			prod_o = QNAN;
			status_o[ST_NV] = 1'b1;
		end else if (a_inf || b_inf) begin
			prod_o = {sp, 5'(EXP_MAX), {FRAC_W{1'b0}}};
		end else if (a_zero || b_zero) begin
			prod_o = {sp, 15'b0};
		end else if (exp_n <= 0) begin
			// Below normal range, flush to signed zero
			prod_o = {sp, 15'b0};
			status_o[ST_UF] = 1'b1;
			status_o[ST_NX] = 1'b1;
		end else if (exp_r >= EXP_MAX) begin
			prod_o = {sp, 5'(EXP_MAX), {FRAC_W{1'b0}}};
			status_o[ST_OF] = 1'b1;
			status_o[ST_NX] = 1'b1;
		end else begin
			prod_o = {sp, exp_r[EXP_W-1:0], frac_r};
			status_o[ST_NX] = guard | sticky;
		end
	end

endmodule

// ==== fp16_add.sv ====
//--------------------
// FP16 adder datapath
// Alignment with guard, round and sticky bits
// Normalization and round-to-nearest-even
//--------------------

module fp16_add (
	input  fp16_pkg::fp16_t   a_i,
	input  fp16_pkg::fp16_t   b_i,
	output fp16_pkg::fp16_t   sum_o,
	output fp16_pkg::status_t status_o
);
	import fp16_pkg::*;

	logic              sa, sb;
	logic [EXP_W-1:0]  ea, eb;
	logic [FRAC_W-1:0] fa, fb;
	logic              a_zero, b_zero, a_inf, b_inf, a_nan, b_nan, any_snan;
	logic [14:0]       mag_a, mag_b;
	logic              a_ge;
	logic              s_l, s_s, eff_sub;
	logic [EXP_W-1:0]  e_l, e_s, d;
	logic [FRAC_W-1:0] f_l, f_s;
	logic [10:0]       m_l, m_s;
	logic [26:0]       sh;
	logic [13:0]       large_al, small_al;
	logic [14:0]       raw;
	logic [3:0]        lz;
	logic [13:0]       norm;
	logic signed [7:0] exp_n, exp_r;
	logic              rnd_up, inexact;
	logic [11:0]       sig_r;
	logic [FRAC_W-1:0] frac_r;

	// Unpack fields
	assign sa = a_i[15];
	assign sb = b_i[15];
	assign ea = a_i[FRAC_W +: EXP_W];
	assign eb = b_i[FRAC_W +: EXP_W];
	assign fa = a_i[FRAC_W-1:0];
	assign fb = b_i[FRAC_W-1:0];

	// Subnormals count as zero
	assign a_zero = (ea == '0);
	assign b_zero = (eb == '0);
	assign a_inf  = (ea == EXP_MAX) && (fa == '0);
	assign b_inf  = (eb == EXP_MAX) && (fb == '0);
	assign a_nan  = (ea == EXP_MAX) && (fa != '0);
	assign b_nan  = (eb == EXP_MAX) && (fb != '0);
	// Signaling NaN has the quiet bit clear
	assign any_snan = (a_nan && !fa[FRAC_W-1]) || (b_nan && !fb[FRAC_W-1]);

	// Magnitudes with flushed inputs forced to zero
	assign mag_a = a_zero ? '0 : a_i[14:0];
	assign mag_b = b_zero ? '0 : b_i[14:0];
	assign a_ge  = (mag_a >= mag_b);

	// Order operands by magnitude
	assign s_l = a_ge ? sa : sb;
	assign s_s = a_ge ? sb : sa;
	assign e_l = a_ge ? mag_a[14:10] : mag_b[14:10];
	assign e_s = a_ge ? mag_b[14:10] : mag_a[14:10];
	assign f_l = a_ge ? mag_a[9:0] : mag_b[9:0];
	assign f_s = a_ge ? mag_b[9:0] : mag_a[9:0];

	// Hidden bit only for nonzero exponent
	assign m_l = {e_l != '0, f_l};
	assign m_s = {e_s != '0, f_s};

	// Align smaller significand, lost bits collapse into sticky
	assign d  = e_l - e_s;
	assign sh = {m_s, 16'b0} >> d;
	assign small_al = (d >= 5'd14) ? {13'b0, |m_s} : {sh[26:14], |sh[13:0]};
	assign large_al = {m_l, 3'b000};

	// Magnitude add or subtract, larger minus smaller never goes negative
	assign eff_sub = s_l ^ s_s;
	assign raw = eff_sub ? {1'b0, large_al} - {1'b0, small_al}
		: {1'b0, large_al} + {1'b0, small_al};

	// Distance of leading one from the hidden bit position
	always_comb begin
		lz = '0;
		for (int i = 0; i < 14; i++) begin
			if (raw[i]) begin
				lz = 4'(13 - i);
			end
		end
	end

	// Normalize
	always_comb begin
		if (raw[14]) begin
			// Carry out, shift right and keep sticky
			norm  = {raw[14:2], raw[1] | raw[0]};
			exp_n = $signed({3'b000, e_l}) + 8'sd1;
		end else begin
			norm  = raw[13:0] << lz;
			exp_n = $signed({3'b000, e_l}) - $signed({4'b0000, lz});
		end
	end

	// Round to nearest, ties to even
	assign rnd_up  = norm[2] & (norm[1] | norm[0] | norm[3]);
	assign inexact = |norm[2:0];
	assign sig_r   = {1'b0, norm[13:3]} + {11'b0, rnd_up};
	// Rounding carry bumps the exponent
	assign exp_r   = sig_r[11] ? exp_n + 8'sd1 : exp_n;
	assign frac_r  = sig_r[11] ? sig_r[10:1] : sig_r[9:0];

	// Special cases first, then range checks
	always_comb begin
		sum_o    = '0;
		status_o = '0;
		if (a_nan || b_nan) begin
			sum_o = QNAN;
			status_o[ST_NV] = any_snan;
		end else if (a_inf && b_inf && (sa != sb)) begin
			sum_o = QNAN;
			status_o[ST_NV] = 1'b1;
		end else if (a_inf || b_inf) begin
			sum_o = a_inf ? a_i : b_i;
		end else if (raw == '0) begin
			// Exact zero is positive unless both inputs were negative
			sum_o = {s_l & s_s, 15'b0};
		end else if (exp_n <= 0) begin
			sum_o = {s_l, 15'b0};
			status_o[ST_UF] = 1'b1;
			status_o[ST_NX] = 1'b1;
		end else if (exp_r >= EXP_MAX) begin
			sum_o = {s_l, 5'(EXP_MAX), {FRAC_W{1'b0}}};
			status_o[ST_OF] = 1'b1;
			status_o[ST_NX] = 1'b1;
		end else begin
			sum_o = {s_l, exp_r[EXP_W-1:0], frac_r};
			status_o[ST_NX] = inexact;
		end
	end

endmodule

// ==== fp16_pkg.sv ====
//--------------------
// FP16 unit package
// Field widths, bias and special encodings
// ALU and core operation codes, status bit layout
//--------------------

package fp16_pkg;

	// IEEE 754 binary16 layout
	localparam int EXP_W    = 5;
	localparam int FRAC_W   = 10;
	localparam int EXP_BIAS = 15;

	// All-ones exponent marks infinity or NaN
	localparam int EXP_MAX = 31;

	// Register stages between request and result
	localparam int PIPE_DEPTH = 2;

	// Raw half-precision value
	typedef logic [15:0] fp16_t;

	// Host side operation code
	typedef logic [1:0] alu_op_t;

	localparam alu_op_t ALU_ADD = 2'd0;
	localparam alu_op_t ALU_SUB = 2'd1;
	localparam alu_op_t ALU_MUL = 2'd2;

	// Core operations, subtraction arrives as add with b negated
	typedef enum logic {
		FPU_ADD = 1'b0,
		FPU_MUL = 1'b1
	} fpu_op_e;

	// Exception flags, NV in the top bit
	typedef logic [3:0] status_t;

	localparam int ST_NV = 3;
	localparam int ST_OF = 2;
	localparam int ST_UF = 1;
	localparam int ST_NX = 0;

	// Canonical quiet NaN
	localparam fp16_t QNAN = 16'h7E00;

endpackage
